//--- compile.f
logic/cpu_core_pkg.sv
logic/cpu_opcode_pkg.sv
logic/cpu_alu.sv
logic/cpu_control.sv
logic/cpu_datapath.sv
logic/cpu_top.sv
test/tb_cpu_mem.sv
test/tb_cpu.sv

//--- logic/cpu_alu.sv
`timescale 1ns/1ps
// 8-bit ALU
// Binary add with carry; SBC and CMP add the inverted operand.
// Logic ops AND, ORA, EOR. Result and N V Z C flags in the same cycle
module cpu_alu
  import cpu_core_pkg::*;
(
  input  alu_op_t alu_op,
  input  data_t   alu_a,
  input  data_t   alu_b,
  input  logic    alu_carry_in,
  output data_t   alu_result,
  output status_t alu_flags
);

  data_t      b_eff;
  logic       c_eff;
  logic [8:0] sum;
  logic       is_arith;
  data_t      flag_src;

  // Subtract as add of the one's complement
  assign b_eff    = (alu_op == ALU_SBC || alu_op == ALU_CMP) ? ~alu_b : alu_b;
  // Compare never borrows
  assign c_eff    = (alu_op == ALU_CMP) ? 1'b1 : alu_carry_in;
  assign sum      = {1'b0, alu_a} + {1'b0, b_eff} + {8'h00, c_eff};
  assign is_arith = (alu_op == ALU_ADC) || (alu_op == ALU_SBC);

  // Value the N and Z flags look at
  always_comb begin
    case (alu_op)
      ALU_AND: flag_src = alu_a & alu_b;
      ALU_ORA: flag_src = alu_a | alu_b;
      ALU_EOR: flag_src = alu_a ^ alu_b;
      default: flag_src = sum[7:0];
    endcase
  end

  // CMP hands A back untouched
  assign alu_result = (alu_op == ALU_CMP) ? alu_a : flag_src;

  always_comb begin
    alu_flags         = '0;
    alu_flags[FLAG_N] = flag_src[7];
    alu_flags[FLAG_Z] = (flag_src == 8'h00);
    // Logic ops return the incoming carry so C stays put
    alu_flags[FLAG_C] = (is_arith || alu_op == ALU_CMP) ? sum[8] : alu_carry_in;
    // Overflow when both inputs share a sign the result does not
    alu_flags[FLAG_V] = (alu_a[7] == b_eff[7]) && (sum[7] != alu_a[7]);
    // V only meaningful for ADC and SBC
    alu_flags[FLAG_U] = is_arith;
  end

endmodule

//--- logic/cpu_control.sv
`timescale 1ns/1ps
// CPU control
// Instruction register, opcode decoder and the cycle FSM.
// Decodes the opcode into class signals for the datapath and ALU,
// and halts on any opcode it does not know
module cpu_control
  import cpu_core_pkg::*;
  import cpu_opcode_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  data_t      rd_data,
  output cpu_state_t state,
  output exec_kind_t exec_kind,
  output reg_sel_t   reg_sel,
  output alu_op_t    alu_op,
  output flag_op_t   flag_op,
  output logic       halted
);

  data_t      ir;
  cpu_state_t state_next;
  logic       op_known;

  // -------------------------------------------------------------------------
  // Instruction register loaded with the opcode byte in FETCH
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ir <= OP_NOP;
    end else if (state == ST_FETCH) begin
      ir <= rd_data;
    end
  end

  // -------------------------------------------------------------------------
  // Opcode decoder
  // -------------------------------------------------------------------------
  always_comb begin
    op_known = 1'b1;
    case (ir)
      OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM: exec_kind = EX_LOAD_IMM;
      OP_LDA_ABS, OP_LDX_ABS, OP_LDY_ABS: exec_kind = EX_LOAD_ABS;
      OP_STA_ABS, OP_STX_ABS, OP_STY_ABS: exec_kind = EX_STORE;
      OP_ADC_ABS, OP_SBC_ABS, OP_AND_ABS,
      OP_ORA_ABS, OP_EOR_ABS, OP_CMP_ABS: exec_kind = EX_ALU;
      OP_JMP_ABS:                         exec_kind = EX_JMP;
      OP_CLC, OP_SEC, OP_CLV:             exec_kind = EX_FLAG;
      OP_NOP:                             exec_kind = EX_NOP;
      default: begin
        // Unknown opcode runs as NOP on the way to halt
        exec_kind = EX_NOP;
        op_known  = 1'b0;
      end
    endcase

    // Register select
    case (ir)
      OP_LDX_IMM, OP_LDX_ABS, OP_STX_ABS: reg_sel = RS_X;
      OP_LDY_IMM, OP_LDY_ABS, OP_STY_ABS: reg_sel = RS_Y;
      default:                            reg_sel = RS_A;
    endcase

    // ALU operation
    case (ir)
      OP_SBC_ABS: alu_op = ALU_SBC;
      OP_AND_ABS: alu_op = ALU_AND;
      OP_ORA_ABS: alu_op = ALU_ORA;
      OP_EOR_ABS: alu_op = ALU_EOR;
      OP_CMP_ABS: alu_op = ALU_CMP;
      default:    alu_op = ALU_ADC;
    endcase

    // Flag instructions
    case (ir)
      OP_CLC:  flag_op = FL_CLC;
      OP_SEC:  flag_op = FL_SEC;
      OP_CLV:  flag_op = FL_CLV;
      default: flag_op = FL_NONE;
    endcase
  end

  // -------------------------------------------------------------------------
  // Cycle FSM
  // -------------------------------------------------------------------------
  always_comb begin
    case (state)
      ST_RESET:  state_next = ST_VEC_LO;
      ST_VEC_LO: state_next = ST_VEC_HI;
      ST_VEC_HI: state_next = ST_FETCH;
      ST_FETCH:  state_next = ST_DECODE;
      ST_DECODE: begin
        if (!op_known) begin
          state_next = ST_HALT;
        end else if (exec_kind inside {EX_LOAD_ABS, EX_STORE, EX_ALU, EX_JMP}) begin
          state_next = ST_ABS_LO;
        end else begin
          // Immediate and implied finish here
          state_next = ST_FETCH;
        end
      end
      // JMP is done once the high address byte is in
      ST_ABS_LO:   state_next = (exec_kind == EX_JMP) ? ST_FETCH : ST_ABS_EXEC;
      ST_ABS_EXEC: state_next = ST_FETCH;
      // Halt holds until reset
      default:     state_next = ST_HALT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= ST_RESET;
    end else begin
      state <= state_next;
    end
  end

  assign halted = (state == ST_HALT);

endmodule

//--- logic/cpu_core_pkg.sv
// CPU core shared types
// Bus widths, P register bit positions, the cycle FSM states and the
// decoded instruction classes that pass between control, datapath and ALU
package cpu_core_pkg;

  // -------------------------------------------------------------------------
  // Bus and register widths
  // -------------------------------------------------------------------------
  typedef logic [7:0]  data_t;
  typedef logic [15:0] addr_t;
  typedef logic [7:0]  status_t;

  // Bit positions within P
  localparam int FLAG_C = 0;
  localparam int FLAG_Z = 1;
  // Reads 1 in P; on the ALU flag output it marks V as live
  localparam int FLAG_U = 5;
  localparam int FLAG_V = 6;
  localparam int FLAG_N = 7;

  // -------------------------------------------------------------------------
  // Cycle FSM
  // -------------------------------------------------------------------------
  typedef enum logic [2:0] {
    ST_RESET,
    ST_VEC_LO,
    ST_VEC_HI,
    ST_FETCH,
    ST_DECODE,
    ST_ABS_LO,
    ST_ABS_EXEC,
    ST_HALT
  } cpu_state_t;

  // -------------------------------------------------------------------------
  // Decoded instruction classes
  // -------------------------------------------------------------------------
  typedef enum logic [2:0] {
    EX_LOAD_IMM,
    EX_LOAD_ABS,
    EX_STORE,
    EX_ALU,
    EX_JMP,
    EX_FLAG,
    EX_NOP
  } exec_kind_t;

  // Load target or store source
  typedef enum logic [1:0] {RS_A, RS_X, RS_Y} reg_sel_t;

  typedef enum logic [2:0] {ALU_ADC, ALU_SBC, ALU_AND, ALU_ORA, ALU_EOR, ALU_CMP} alu_op_t;

  // Implied flag instructions
  typedef enum logic [1:0] {FL_CLC, FL_SEC, FL_CLV, FL_NONE} flag_op_t;

endpackage

//--- logic/cpu_datapath.sv
`timescale 1ns/1ps
// CPU datapath
// A, X, Y, PC and P registers, operand capture and the memory bus
// registers. Steps the address through vector, operand and next
// opcode, and updates P from loads, ALU results and flag instructions
module cpu_datapath
  import cpu_core_pkg::*;
#(
  parameter addr_t RESET_VECTOR = 16'hFFFC
) (
  input  logic       clk,
  input  logic       resetn,
  input  data_t      rd_data,
  input  cpu_state_t state,
  input  exec_kind_t exec_kind,
  input  reg_sel_t   reg_sel,
  input  flag_op_t   flag_op,
  input  data_t      alu_result,
  input  status_t    alu_flags,
  output addr_t      address,
  output data_t      wr_data,
  output logic       wr_enable,
  output data_t      alu_a,
  output data_t      alu_b,
  output logic       alu_carry_in
);

  data_t   a_reg;
  data_t   x_reg;
  data_t   y_reg;
  addr_t   pc;
  status_t p_reg;
  data_t   operand_lo;
  addr_t   operand_addr;
  data_t   store_val;
  logic    short_instr;
  logic    load_en;
  logic    alu_en;

  // Full operand address once the high byte is on rd_data
  assign operand_addr = {rd_data, operand_lo};
  // One-byte instructions
  assign short_instr  = (exec_kind == EX_FLAG) || (exec_kind == EX_NOP);

  // Loaded byte is on rd_data in both load paths
  assign load_en = ((state == ST_DECODE) && (exec_kind == EX_LOAD_IMM)) ||
                   ((state == ST_ABS_EXEC) && (exec_kind == EX_LOAD_ABS));
  assign alu_en  = (state == ST_ABS_EXEC) && (exec_kind == EX_ALU);

  always_comb begin
    case (reg_sel)
      RS_X:    store_val = x_reg;
      RS_Y:    store_val = y_reg;
      default: store_val = a_reg;
    endcase
  end

  // ALU takes A and the memory byte, carry from P
  assign alu_a        = a_reg;
  assign alu_b        = rd_data;
  assign alu_carry_in = p_reg[FLAG_C];

  // -------------------------------------------------------------------------
  // Memory bus sequencing
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      address   <= RESET_VECTOR;
      wr_enable <= 1'b0;
    end else begin
      // Strobe covers exactly the ABS_EXEC cycle of a store
      wr_enable <= (state == ST_ABS_LO) && (exec_kind == EX_STORE);
      case (state)
        ST_VEC_LO:   address <= RESET_VECTOR + 16'd1;
        ST_VEC_HI:   address <= {rd_data, pc[7:0]};
        // Operand byte, or next opcode for implied
        ST_FETCH:    address <= pc + 16'd1;
        ST_DECODE:   address <= short_instr ? pc + 16'd1 : pc + 16'd2;
        ST_ABS_LO:   address <= operand_addr;
        ST_ABS_EXEC: address <= pc + 16'd3;
        // Reset and halt hold the bus
        default: begin
        end
      endcase
    end
  end

  // -------------------------------------------------------------------------
  // Program counter pointing at the opcode while in FETCH
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    case (state)
      ST_VEC_LO: pc[7:0]  <= rd_data;
      ST_VEC_HI: pc[15:8] <= rd_data;
      ST_DECODE: begin
        if (exec_kind == EX_LOAD_IMM) begin
          pc <= pc + 16'd2;
        end else if (short_instr) begin
          pc <= pc + 16'd1;
        end
      end
      ST_ABS_LO: begin
        if (exec_kind == EX_JMP) begin
          pc <= operand_addr;
        end
      end
      ST_ABS_EXEC: pc <= pc + 16'd3;
      default: begin
      end
    endcase
  end

  // -------------------------------------------------------------------------
  // A, X, Y, operand low byte and store data
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (load_en) begin
      case (reg_sel)
        RS_X:    x_reg <= rd_data;
        RS_Y:    y_reg <= rd_data;
        default: a_reg <= rd_data;
      endcase
    end else if (alu_en) begin
      // CMP comes back as A itself
      a_reg <= alu_result;
    end
    if (state == ST_DECODE) begin
      operand_lo <= rd_data;
    end
    if (state == ST_ABS_LO) begin
      wr_data <= store_val;
    end
  end

  // -------------------------------------------------------------------------
  // Status register
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      p_reg         <= '0;
      p_reg[FLAG_U] <= 1'b1;
    end else if (load_en) begin
      p_reg[FLAG_N] <= rd_data[7];
      p_reg[FLAG_Z] <= (rd_data == 8'h00);
    end else if (alu_en) begin
      p_reg[FLAG_N] <= alu_flags[FLAG_N];
      p_reg[FLAG_Z] <= alu_flags[FLAG_Z];
      // Logic ops return the old carry
      p_reg[FLAG_C] <= alu_flags[FLAG_C];
      // V only for ADC and SBC
      if (alu_flags[FLAG_U]) begin
        p_reg[FLAG_V] <= alu_flags[FLAG_V];
      end
    end else if ((state == ST_DECODE) && (exec_kind == EX_FLAG)) begin
      case (flag_op)
        FL_CLC:  p_reg[FLAG_C] <= 1'b0;
        FL_SEC:  p_reg[FLAG_C] <= 1'b1;
        FL_CLV:  p_reg[FLAG_V] <= 1'b0;
        default: begin
        end
      endcase
    end
  end

endmodule

//--- logic/cpu_opcode_pkg.sv
// 6502 opcode values
// Standard encodings for the instructions this core executes;
// anything else halts the core
package cpu_opcode_pkg;
  import cpu_core_pkg::*;

  // Immediate loads
  localparam data_t OP_LDA_IMM = 8'hA9;
  localparam data_t OP_LDX_IMM = 8'hA2;
  localparam data_t OP_LDY_IMM = 8'hA0;

  // Implied
  localparam data_t OP_CLC     = 8'h18;
  localparam data_t OP_SEC     = 8'h38;
  localparam data_t OP_CLV     = 8'hB8;
  localparam data_t OP_NOP     = 8'hEA;

  // Absolute
  localparam data_t OP_JMP_ABS = 8'h4C;
  localparam data_t OP_LDA_ABS = 8'hAD;
  localparam data_t OP_LDX_ABS = 8'hAE;
  localparam data_t OP_LDY_ABS = 8'hAC;
  localparam data_t OP_STA_ABS = 8'h8D;
  localparam data_t OP_STX_ABS = 8'h8E;
  localparam data_t OP_STY_ABS = 8'h8C;
  localparam data_t OP_ADC_ABS = 8'h6D;
  localparam data_t OP_SBC_ABS = 8'hED;
  localparam data_t OP_AND_ABS = 8'h2D;
  localparam data_t OP_ORA_ABS = 8'h0D;
  localparam data_t OP_EOR_ABS = 8'h4D;
  localparam data_t OP_CMP_ABS = 8'hCD;

endpackage

//--- logic/cpu_top.sv
`timescale 1ns/1ps
// CPU top level
// Control FSM, datapath and ALU on a byte-wide memory bus with
// registered address, same-cycle read data and a write strobe
module cpu_top
  import cpu_core_pkg::*;
#(
  parameter addr_t RESET_VECTOR = 16'hFFFC
) (
  input  logic  clk,
  input  logic  resetn,
  input  data_t rd_data,
  output addr_t address,
  output data_t wr_data,
  output logic  wr_enable,
  output logic  halted
);

  // Control to datapath and ALU
  cpu_state_t state;
  exec_kind_t exec_kind;
  reg_sel_t   reg_sel;
  alu_op_t    alu_op;
  flag_op_t   flag_op;

  // Datapath to ALU and back
  data_t      alu_a;
  data_t      alu_b;
  logic       alu_carry_in;
  data_t      alu_result;
  status_t    alu_flags;

  cpu_control control_inst (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .state     (state),
    .exec_kind (exec_kind),
    .reg_sel   (reg_sel),
    .alu_op    (alu_op),
    .flag_op   (flag_op),
    .halted    (halted)
  );

  cpu_datapath #(
    .RESET_VECTOR (RESET_VECTOR)
  ) datapath_inst (
    .clk          (clk),
    .resetn       (resetn),
    .rd_data      (rd_data),
    .state        (state),
    .exec_kind    (exec_kind),
    .reg_sel      (reg_sel),
    .flag_op      (flag_op),
    .alu_result   (alu_result),
    .alu_flags    (alu_flags),
    .address      (address),
    .wr_data      (wr_data),
    .wr_enable    (wr_enable),
    .alu_a        (alu_a),
    .alu_b        (alu_b),
    .alu_carry_in (alu_carry_in)
  );

  cpu_alu alu_inst (
    .alu_op       (alu_op),
    .alu_a        (alu_a),
    .alu_b        (alu_b),
    .alu_carry_in (alu_carry_in),
    .alu_result   (alu_result),
    .alu_flags    (alu_flags)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the CPU testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_cpu -Mdir obj_dir -f compile.f &&
  sim_output="$(./obj_dir/Vtb_cpu)" &&
  echo "$sim_output" &&
  grep -qx '>>> PASS' <<< "$sim_output" ||
  { echo "Simulation did not pass"; exit 1; }

//--- test/tb_cpu.sv
`timescale 1ns/1ps
// CPU testbench
// Builds small programs in the memory model, runs each from the reset
// vector and checks every store against 6502 arithmetic
module tb_cpu
  import cpu_core_pkg::*;
  import cpu_opcode_pkg::*;
();

  localparam addr_t RESET_VECTOR = 16'hFFFC;
  localparam addr_t ORIGIN       = 16'h0200;
  localparam int    WAIT_LIMIT   = 100;
  // Not an opcode this core knows
  localparam data_t UNKNOWN_OP   = 8'h02;

  logic        clk;
  logic        resetn;
  data_t       rd_data;
  addr_t       address;
  data_t       wr_data;
  logic        wr_enable;
  logic        halted;
  logic        load_en;
  addr_t       load_addr;
  data_t       load_data;
  logic [15:0] write_count;
  addr_t       last_addr;
  data_t       last_data;

  int          errors;
  logic [15:0] seen_writes;
  logic [31:0] lfsr_state;
  addr_t       org;
  // Memory image of the next program
  addr_t       image_addr[$];
  data_t       image_data[$];

  cpu_top #(
    .RESET_VECTOR (RESET_VECTOR)
  ) cpu_top_inst (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable),
    .halted    (halted)
  );

  tb_cpu_mem mem_inst (
    .clk         (clk),
    .resetn      (resetn),
    .address     (address),
    .wr_data     (wr_data),
    .wr_enable   (wr_enable),
    .load_en     (load_en),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .rd_data     (rd_data),
    .write_count (write_count),
    .last_addr   (last_addr),
    .last_data   (last_data)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // -------------------------------------------------------------------------
  // Random bytes from a Fibonacci LFSR with taps 32 22 2 1
  // -------------------------------------------------------------------------
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic data_t rand_byte();
    data_t b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      b = {b[6:0], lfsr_bit()};
    end
    return b;
  endfunction

  // -------------------------------------------------------------------------
  // Compare tasks
  // -------------------------------------------------------------------------
  task automatic check_byte(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // -------------------------------------------------------------------------
  // Program building
  // -------------------------------------------------------------------------
  task automatic place_data(input addr_t where, input data_t value);
    image_addr.push_back(where);
    image_data.push_back(value);
  endtask

  task automatic emit_byte(input data_t value);
    place_data(org, value);
    org = org + 16'd1;
  endtask

  task automatic emit_imm(input data_t op, input data_t value);
    emit_byte(op);
    emit_byte(value);
  endtask

  // Operand little endian as on the 6502
  task automatic emit_abs(input data_t op, input addr_t target);
    emit_byte(op);
    emit_byte(target[7:0]);
    emit_byte(target[15:8]);
  endtask

  task automatic begin_program();
    image_addr.delete();
    image_data.delete();
    place_data(RESET_VECTOR, ORIGIN[7:0]);
    place_data(RESET_VECTOR + 16'd1, ORIGIN[15:8]);
    org = ORIGIN;
  endtask

  // Load the image, pulse reset, check the bus and release
  task automatic run_program();
    foreach (image_addr[i]) begin
      load_en   = 1'b1;
      load_addr = image_addr[i];
      load_data = image_data[i];
      @(negedge clk);
    end
    load_en = 1'b0;
    resetn  = 1'b0;
    repeat (3) @(negedge clk);
    check_addr("reset address", RESET_VECTOR, address);
    if (wr_enable || halted) begin
      $display("Error: write strobe or halted is high during reset");
      errors++;
    end
    seen_writes = '0;
    resetn      = 1'b1;
  endtask

  // -------------------------------------------------------------------------
  // Waits on the DUT
  // -------------------------------------------------------------------------
  task automatic expect_write(input string name, input addr_t exp_addr, input data_t exp_data);
    int waited;
    waited = 0;
    while (write_count == seen_writes && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (write_count == seen_writes) begin
      $display("Error: %s timed out waiting for a memory write", name);
      errors++;
    end else begin
      seen_writes = seen_writes + 16'd1;
      check_addr(name, exp_addr, last_addr);
      check_byte(name, exp_data, last_data);
    end
  endtask

  task automatic wait_halt(input string name);
    int waited;
    waited = 0;
    while (!halted && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!halted) begin
      $display("Error: %s never raised halted", name);
      errors++;
    end
  endtask

  task automatic expect_quiet(input string name, input int cycles);
    repeat (cycles) @(negedge clk);
    if (write_count != seen_writes) begin
      $display("Error: %s wrote to %h after it should have stopped", name, last_addr);
      errors++;
    end
    if (!halted) begin
      $display("Error: %s left the halt state", name);
      errors++;
    end
  endtask

  // -------------------------------------------------------------------------
  // Directed tests
  // -------------------------------------------------------------------------
  task automatic reset_and_immediate();
    data_t va;
    data_t vx;
    data_t vy;
    va = rand_byte();
    vx = rand_byte();
    vy = rand_byte();
    begin_program();
    emit_imm(OP_LDA_IMM, va);
    emit_byte(OP_NOP);
    emit_abs(OP_STA_ABS, 16'h0300);
    emit_imm(OP_LDX_IMM, vx);
    emit_abs(OP_STX_ABS, 16'h0301);
    emit_imm(OP_LDY_IMM, vy);
    emit_abs(OP_STY_ABS, 16'h0302);
    emit_byte(UNKNOWN_OP);
    run_program();
    expect_write("lda imm", 16'h0300, va);
    expect_write("ldx imm", 16'h0301, vx);
    expect_write("ldy imm", 16'h0302, vy);
  endtask

  task automatic load_store_absolute();
    data_t va;
    data_t vy;
    va = rand_byte();
    vy = rand_byte();
    begin_program();
    place_data(16'h0400, va);
    place_data(16'h0401, vy);
    emit_abs(OP_LDA_ABS, 16'h0400);
    emit_abs(OP_LDY_ABS, 16'h0401);
    emit_abs(OP_STA_ABS, 16'h0410);
    emit_abs(OP_STY_ABS, 16'h0411);
    emit_byte(UNKNOWN_OP);
    run_program();
    expect_write("lda abs", 16'h0410, va);
    expect_write("ldy abs", 16'h0411, vy);
  endtask

  task automatic arithmetic_with_carry(input string name, input logic is_sbc, input logic carry);
    data_t a;
    data_t b;
    data_t expected;
    a = rand_byte();
    b = rand_byte();
    // Borrow is the inverted carry
    if (is_sbc) begin
      expected = a - b - data_t'(!carry);
    end else begin
      expected = a + b + data_t'(carry);
    end
    begin_program();
    place_data(16'h0500, b);
    // Opposite carry first so the flag instruction has to change it
    emit_byte(carry ? OP_CLC : OP_SEC);
    emit_byte(carry ? OP_SEC : OP_CLC);
    emit_byte(OP_CLV);
    emit_imm(OP_LDA_IMM, a);
    emit_abs(is_sbc ? OP_SBC_ABS : OP_ADC_ABS, 16'h0500);
    emit_abs(OP_STA_ABS, 16'h0510);
    emit_byte(UNKNOWN_OP);
    run_program();
    expect_write(name, 16'h0510, expected);
  endtask

  task automatic logic_ops();
    data_t a;
    data_t b;
    a = rand_byte();
    b = rand_byte();
    begin_program();
    place_data(16'h0600, b);
    emit_imm(OP_LDA_IMM, a);
    emit_abs(OP_AND_ABS, 16'h0600);
    emit_abs(OP_STA_ABS, 16'h0610);
    emit_imm(OP_LDA_IMM, a);
    emit_abs(OP_ORA_ABS, 16'h0600);
    emit_abs(OP_STA_ABS, 16'h0611);
    emit_imm(OP_LDA_IMM, a);
    emit_abs(OP_EOR_ABS, 16'h0600);
    emit_abs(OP_STA_ABS, 16'h0612);
    emit_byte(UNKNOWN_OP);
    run_program();
    expect_write("and", 16'h0610, a & b);
    expect_write("ora", 16'h0611, a | b);
    expect_write("eor", 16'h0612, a ^ b);
  endtask

  // Carry from CMP made visible by adding it to zero
  task automatic compare_flags(input string name, input data_t a, input data_t b);
    begin_program();
    place_data(16'h0700, b);
    place_data(16'h0701, 8'h00);
    // Carry going in is the opposite of what CMP must leave
    emit_byte((a >= b) ? OP_CLC : OP_SEC);
    emit_imm(OP_LDA_IMM, a);
    emit_abs(OP_CMP_ABS, 16'h0700);
    emit_abs(OP_STA_ABS, 16'h0711);
    emit_imm(OP_LDA_IMM, 8'h00);
    emit_abs(OP_ADC_ABS, 16'h0701);
    emit_abs(OP_STA_ABS, 16'h0710);
    emit_byte(UNKNOWN_OP);
    run_program();
    expect_write({name, " keeps A"}, 16'h0711, a);
    expect_write({name, " carry"}, 16'h0710, (a >= b) ? 8'h01 : 8'h00);
  endtask

  task automatic jump_skip();
    data_t v;
    v = rand_byte();
    begin_program();
    emit_imm(OP_LDA_IMM, v);
    emit_abs(OP_JMP_ABS, 16'h0220);
    // Marker store the jump passes over
    emit_abs(OP_STA_ABS, 16'h07F0);
    emit_byte(UNKNOWN_OP);
    org = 16'h0220;
    emit_abs(OP_STA_ABS, 16'h0720);
    emit_byte(UNKNOWN_OP);
    run_program();
    expect_write("jmp target store", 16'h0720, v);
    wait_halt("jmp");
    expect_quiet("jmp", 20);
  endtask

  task automatic halt_on_unknown();
    data_t v;
    v = rand_byte();
    begin_program();
    emit_imm(OP_LDA_IMM, v);
    emit_byte(UNKNOWN_OP);
    // Never reached
    emit_abs(OP_STA_ABS, 16'h0730);
    run_program();
    wait_halt("halt");
    expect_quiet("halt", 20);
  endtask

  // -------------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------------
  initial begin
    data_t cmp_a;
    data_t cmp_b;
    clk         = 1'b0;
    resetn      = 1'b0;
    load_en     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    errors      = 0;
    seen_writes = '0;
    lfsr_state  = 32'h5920_a451;
    org         = ORIGIN;

    reset_and_immediate();
    load_store_absolute();
    arithmetic_with_carry("adc c0", 1'b0, 1'b0);
    arithmetic_with_carry("adc c1", 1'b0, 1'b1);
    arithmetic_with_carry("sbc c0", 1'b1, 1'b0);
    arithmetic_with_carry("sbc c1", 1'b1, 1'b1);
    logic_ops();

    // A at or above the operand
    cmp_b = rand_byte() & 8'h7F;
    cmp_a = cmp_b + (rand_byte() & 8'h7F);
    compare_flags("cmp ge", cmp_a, cmp_b);
    // A strictly below
    cmp_a = rand_byte() & 8'h7F;
    cmp_b = cmp_a + 8'd1 + (rand_byte() & 8'h3F);
    compare_flags("cmp lt", cmp_a, cmp_b);

    jump_skip();
    halt_on_unknown();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- test/tb_cpu_mem.sv
`timescale 1ns/1ps
// Testbench memory model
// 64 KiB byte array with same-cycle read and clocked write. A load port
// fills it between runs while the core is held in reset or halted, and
// a monitor counts core writes and keeps the last address and byte written
module tb_cpu_mem
  import cpu_core_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  addr_t       address,
  input  data_t       wr_data,
  input  logic        wr_enable,
  input  logic        load_en,
  input  addr_t       load_addr,
  input  data_t       load_data,
  output data_t       rd_data,
  output logic [15:0] write_count,
  output addr_t       last_addr,
  output data_t       last_data
);

  data_t mem [0:65535];

  // Read data follows the address within the cycle
  assign rd_data = mem[address];

  // Program load wins over a core write
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end else if (wr_enable) begin
      mem[address] <= wr_data;
    end
  end

  // -------------------------------------------------------------------------
  // Write monitor
  // -------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      write_count <= '0;
    end else if (wr_enable) begin
      write_count <= write_count + 16'd1;
      last_addr   <= address;
      last_data   <= wr_data;
    end
  end

endmodule
